// ==== src/l2_parser_defines.svh ====
// Layer 2 header front end shared constants
// Header size, runt limit, 802.1Q TPID and APB register map

`ifndef L2_PARSER_DEFINES_SVH
`define L2_PARSER_DEFINES_SVH

// Bytes captured from the start of each frame
`define L2_HDR_BYTES 18

// Smallest frame length that is not a runt
`define L2_MIN_FRAME 20

// 802.1Q tag protocol identifier
`define L2_TPID_VLAN 16'h8100

// ------------------------------
// APB register byte offsets
// ------------------------------
`define L2_REG_CTRL       8'h00
`define L2_REG_MAC_LO     8'h04
`define L2_REG_MAC_HI     8'h08
`define L2_REG_ACCEPT_CNT 8'h0C
`define L2_REG_DROP_CNT   8'h10
`define L2_REG_RUNT_CNT   8'h14

`endif

// ==== src/l2_parser_pkg.sv ====
// Layer 2 header front end types
// Width typedefs, frame FSM states and the structs passed between blocks

`include "l2_parser_defines.svh"

package l2_parser_pkg;

  // ------------------------------
  // Width typedefs
  // ------------------------------
  typedef logic [47:0]                 mac_addr_t;
  typedef logic [15:0]                 ethertype_t;
  typedef logic [11:0]                 vlan_id_t;
  typedef logic [15:0]                 frame_len_t;
  typedef logic [31:0]                 stat_cnt_t;
  typedef logic [7:0]                  apb_addr_t;
  typedef logic [31:0]                 apb_data_t;
  // Byte 0 of the frame sits in bits 7:0
  typedef logic [`L2_HDR_BYTES*8-1:0] hdr_bytes_t;

  // Frame tracking states
  typedef enum logic [1:0] {IDLE, HEADER, BODY, DRAIN} frame_state_t;

  // Decoded header, all fields in network order
  typedef struct packed {
    mac_addr_t  dest_mac;
    mac_addr_t  src_mac;
    ethertype_t ethertype_raw;
    logic [15:0] vlan_tci;
    ethertype_t inner_type;
  } eth_hdr_t;

  // Filter configuration from the register block
  typedef struct packed {
    mac_addr_t station_mac;
    logic      promisc;
    logic      mcast_en;
  } l2_cfg_t;

  // Per-frame summary
  typedef struct packed {
    logic       accept;
    logic       vlan_present;
    vlan_id_t   vlan_id;
    ethertype_t ethertype;
    frame_len_t length;
  } frame_info_t;

  // Single-cycle statistics pulses
  typedef struct packed {
    logic accepted;
    logic dropped;
    logic runt;
  } frame_event_t;

endpackage

// ==== src/byte_counter.sv ====
// Per-frame byte counter
// Gives the index of the byte on the bus, saturating at the top

`timescale 1ns/1ps

module byte_counter (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    rx_valid,
  input  logic                    clear,
  output l2_parser_pkg::frame_len_t byte_idx
);

  // ------------------------------
  // Count register
  // ------------------------------
  // Value equals the bytes taken so far in this frame,
  // so it is also the index of the byte currently offered
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      byte_idx <= '0;
    end else if (clear) begin
      // End of frame wins over the last byte
      byte_idx <= '0;
    end else if (rx_valid && (byte_idx != '1)) begin
      byte_idx <= byte_idx + 1'b1;
    end
  end

endmodule

// ==== src/frame_ctrl_fsm.sv ====
// Frame control FSM
// Tracks header and body of each frame, steers header capture
// and flags frame end or runt on the last byte

`timescale 1ns/1ps
`include "l2_parser_defines.svh"

module frame_ctrl_fsm (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      rx_valid,
  input  logic                      rx_last,
  input  l2_parser_pkg::frame_len_t byte_idx,
  output logic                      capture_en,
  output logic                      header_valid,
  output logic                      frame_end,
  output logic                      runt,
  output logic                      count_clear
);

  import l2_parser_pkg::*;

  frame_state_t state;
  frame_state_t state_nxt;
  logic         last_byte;
  logic         short_frame;
  logic         hdr_done;

  assign last_byte   = rx_valid && rx_last;
  // Length is index plus one
  assign short_frame = (byte_idx < frame_len_t'(`L2_MIN_FRAME - 1));
  assign hdr_done    = rx_valid && (byte_idx == frame_len_t'(`L2_HDR_BYTES - 1));

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE, DRAIN: begin
        // First byte may follow straight after the drain cycle
        if (rx_valid && !rx_last) begin
          state_nxt = HEADER;
        end else begin
          state_nxt = IDLE;
        end
      end
      HEADER: begin
        // Short frame ending inside the header
        if (last_byte) begin
          state_nxt = IDLE;
        end else if (hdr_done) begin
          state_nxt = BODY;
        end
      end
      BODY: begin
        if (last_byte) begin
          state_nxt = DRAIN;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // ------------------------------
  // Outputs
  // ------------------------------
  // Byte 0 arrives while still idle or draining
  assign capture_en   = (state == IDLE) || (state == HEADER) || (state == DRAIN);
  // Header bytes all stored once in body
  assign header_valid = (state == BODY) || (state == DRAIN);
  assign frame_end    = last_byte && (state == BODY) && !short_frame;
  assign runt         = last_byte && short_frame;
  assign count_clear  = frame_end || runt;

endmodule

// ==== src/header_capture.sv ====
// Header capture shift register
// Stores the first header bytes of a frame, byte 0 ending lowest

`timescale 1ns/1ps
`include "l2_parser_defines.svh"

module header_capture (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [7:0]                rx_data,
  input  logic                      rx_valid,
  input  logic                      capture_en,
  output l2_parser_pkg::hdr_bytes_t hdr_bytes
);

  // ------------------------------
  // Shift in from the top
  // ------------------------------
  // After the full header has been shifted,
  // the first byte has reached bits 7:0
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hdr_bytes <= '0;
    end else if (rx_valid && capture_en) begin
      hdr_bytes <= {rx_data, hdr_bytes[`L2_HDR_BYTES*8-1:8]};
    end
  end

endmodule

// ==== src/eth_header_parser.sv ====
// Ethernet L2 header parser
// Pulls MAC addresses, type or TPID, tag control and inner type
// out of the captured bytes, once per header window

`timescale 1ns/1ps

module eth_header_parser (
  input  logic                      clk,
  input  logic                      rst_n,
  input  l2_parser_pkg::hdr_bytes_t hdr_bytes,
  input  logic                      header_valid,
  output l2_parser_pkg::eth_hdr_t   hdr,
  output logic                      fields_valid
);

  import l2_parser_pkg::*;

  // Byte n of the frame
  function automatic logic [7:0] hdr_byte(input hdr_bytes_t b, input int unsigned idx);
    return b[idx*8 +: 8];
  endfunction

  // ------------------------------
  // Field registers
  // ------------------------------
  // Fields are big-endian, first byte is most significant
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hdr          <= '0;
      fields_valid <= 1'b0;
    end else if (header_valid && !fields_valid) begin
      // Destination MAC, bytes 0 to 5
      hdr.dest_mac <= {hdr_byte(hdr_bytes, 0), hdr_byte(hdr_bytes, 1),
                       hdr_byte(hdr_bytes, 2), hdr_byte(hdr_bytes, 3),
                       hdr_byte(hdr_bytes, 4), hdr_byte(hdr_bytes, 5)};
      // Source MAC, bytes 6 to 11
      hdr.src_mac <= {hdr_byte(hdr_bytes, 6), hdr_byte(hdr_bytes, 7),
                      hdr_byte(hdr_bytes, 8), hdr_byte(hdr_bytes, 9),
                      hdr_byte(hdr_bytes, 10), hdr_byte(hdr_bytes, 11)};
      // EtherType or TPID
      hdr.ethertype_raw <= {hdr_byte(hdr_bytes, 12), hdr_byte(hdr_bytes, 13)};
      // Tag control, only meaningful when tagged
      hdr.vlan_tci <= {hdr_byte(hdr_bytes, 14), hdr_byte(hdr_bytes, 15)};
      // Inner type behind the tag
      hdr.inner_type <= {hdr_byte(hdr_bytes, 16), hdr_byte(hdr_bytes, 17)};
      fields_valid   <= 1'b1;
    end else if (!header_valid) begin
      // Window closed, ready for next frame
      fields_valid <= 1'b0;
    end
  end

endmodule

// ==== src/frame_classifier.sv ====
// Frame classifier
// VLAN detection and destination filter, registers one summary
// per frame plus the statistics pulses

`timescale 1ns/1ps
`include "l2_parser_defines.svh"

module frame_classifier (
  input  logic                        clk,
  input  logic                        rst_n,
  input  l2_parser_pkg::eth_hdr_t     hdr,
  input  logic                        fields_valid,
  input  logic                        frame_end,
  input  logic                        runt,
  input  l2_parser_pkg::l2_cfg_t      cfg,
  input  l2_parser_pkg::frame_len_t   length,
  output l2_parser_pkg::frame_info_t  frame_info,
  output logic                        frame_info_valid,
  output l2_parser_pkg::frame_event_t events
);

  import l2_parser_pkg::*;

  logic        is_vlan;
  logic        is_station;
  logic        is_bcast;
  logic        is_mcast;
  logic        fire;
  frame_len_t  len_total;
  frame_info_t info_nxt;

  // ------------------------------
  // Classification
  // ------------------------------
  assign is_vlan    = (hdr.ethertype_raw == ethertype_t'(`L2_TPID_VLAN));
  assign is_station = (hdr.dest_mac == cfg.station_mac);
  assign is_bcast   = (hdr.dest_mac == '1);
  // Group bit is bit 0 of the first byte on the wire
  assign is_mcast   = hdr.dest_mac[40];

  // Index of the last byte plus one, held at the top
  assign len_total = (length == '1) ? length : length + frame_len_t'(1);

  always_comb begin
    info_nxt.accept       = is_station || is_bcast || (is_mcast && cfg.mcast_en) ||
                            cfg.promisc;
    info_nxt.vlan_present = is_vlan;
    info_nxt.vlan_id      = is_vlan ? hdr.vlan_tci[11:0] : '0;
    info_nxt.ethertype    = is_vlan ? hdr.inner_type : hdr.ethertype_raw;
    info_nxt.length       = len_total;
  end

  // Good frame end with the header decoded
  assign fire = frame_end && fields_valid;

  // ------------------------------
  // Pulses
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_info_valid <= 1'b0;
      events           <= '0;
    end else begin
      frame_info_valid <= fire;
      events.accepted  <= fire && info_nxt.accept;
      events.dropped   <= fire && !info_nxt.accept;
      events.runt      <= runt;
    end
  end

  // Summary held until the next frame
  always_ff @(posedge clk) begin
    if (fire) begin
      frame_info <= info_nxt;
    end
  end

endmodule

// ==== src/l2_apb_regs.sv ====
// APB register block
// Station MAC and filter mode configuration, plus accept, drop
// and runt counters cleared by any write

`timescale 1ns/1ps
`include "l2_parser_defines.svh"

module l2_apb_regs (
  input  logic                        clk,
  input  logic                        rst_n,
  input  l2_parser_pkg::apb_addr_t    paddr,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  l2_parser_pkg::apb_data_t    pwdata,
  output l2_parser_pkg::apb_data_t    prdata,
  output logic                        pready,
  output logic                        pslverr,
  input  l2_parser_pkg::frame_event_t events,
  output l2_parser_pkg::l2_cfg_t      cfg
);

  import l2_parser_pkg::*;

  logic      access;
  logic      addr_hit;
  logic      wr_en;
  stat_cnt_t accept_cnt;
  stat_cnt_t drop_cnt;
  stat_cnt_t runt_cnt;

  // Clear wins, otherwise count up and hold at the top
  function automatic stat_cnt_t cnt_next(input stat_cnt_t cnt, input logic clr,
                                         input logic inc);
    if (clr) begin
      return '0;
    end
    if (inc && (cnt != '1)) begin
      return cnt + stat_cnt_t'(1);
    end
    return cnt;
  endfunction

  // ------------------------------
  // Access decode
  // ------------------------------
  assign access = psel && penable;
  assign wr_en  = access && pwrite && addr_hit;

  always_comb begin
    case (paddr)
      `L2_REG_CTRL, `L2_REG_MAC_LO, `L2_REG_MAC_HI,
      `L2_REG_ACCEPT_CNT, `L2_REG_DROP_CNT, `L2_REG_RUNT_CNT: addr_hit = 1'b1;
      default: addr_hit = 1'b0;
    endcase
  end

  // No wait states
  assign pready  = 1'b1;
  assign pslverr = access && !addr_hit;

  // Read mux
  always_comb begin
    case (paddr)
      `L2_REG_CTRL:       prdata = {30'b0, cfg.mcast_en, cfg.promisc};
      `L2_REG_MAC_LO:     prdata = cfg.station_mac[31:0];
      `L2_REG_MAC_HI:     prdata = {16'b0, cfg.station_mac[47:32]};
      `L2_REG_ACCEPT_CNT: prdata = accept_cnt;
      `L2_REG_DROP_CNT:   prdata = drop_cnt;
      `L2_REG_RUNT_CNT:   prdata = runt_cnt;
      default:            prdata = '0;
    endcase
  end

  // ------------------------------
  // Configuration
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg <= '0;
    end else if (wr_en) begin
      case (paddr)
        `L2_REG_CTRL: begin
          cfg.promisc  <= pwdata[0];
          cfg.mcast_en <= pwdata[1];
        end
        `L2_REG_MAC_LO: cfg.station_mac[31:0]  <= pwdata;
        `L2_REG_MAC_HI: cfg.station_mac[47:32] <= pwdata[15:0];
        default: ;
      endcase
    end
  end

  // Statistics, data written is ignored
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      accept_cnt <= '0;
      drop_cnt   <= '0;
      runt_cnt   <= '0;
    end else begin
      accept_cnt <= cnt_next(accept_cnt, wr_en && (paddr == `L2_REG_ACCEPT_CNT),
                             events.accepted);
      drop_cnt   <= cnt_next(drop_cnt, wr_en && (paddr == `L2_REG_DROP_CNT),
                             events.dropped);
      runt_cnt   <= cnt_next(runt_cnt, wr_en && (paddr == `L2_REG_RUNT_CNT),
                             events.runt);
    end
  end

endmodule

// ==== src/l2_parser_top.sv ====
// Receive-side L2 header front end
// Byte stream in, header decode, filter and per-frame summary out,
// configuration and statistics over APB

`timescale 1ns/1ps

module l2_parser_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [7:0]                 rx_data,
  input  logic                       rx_valid,
  input  logic                       rx_last,
  input  l2_parser_pkg::apb_addr_t   paddr,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  l2_parser_pkg::apb_data_t   pwdata,
  output l2_parser_pkg::apb_data_t   prdata,
  output logic                       pready,
  output logic                       pslverr,
  output l2_parser_pkg::frame_info_t frame_info,
  output logic                       frame_info_valid
);

  import l2_parser_pkg::*;

  frame_len_t   byte_idx;
  logic         count_clear;
  logic         capture_en;
  logic         header_valid;
  logic         frame_end;
  logic         runt;
  hdr_bytes_t   hdr_bytes;
  eth_hdr_t     hdr;
  logic         fields_valid;
  l2_cfg_t      cfg;
  frame_event_t events;

  // ------------------------------
  // Stream path
  // ------------------------------
  byte_counter i_byte_counter (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx_valid (rx_valid),
    .clear    (count_clear),
    .byte_idx (byte_idx)
  );

  frame_ctrl_fsm i_frame_ctrl_fsm (
    .clk          (clk),
    .rst_n        (rst_n),
    .rx_valid     (rx_valid),
    .rx_last      (rx_last),
    .byte_idx     (byte_idx),
    .capture_en   (capture_en),
    .header_valid (header_valid),
    .frame_end    (frame_end),
    .runt         (runt),
    .count_clear  (count_clear)
  );

  header_capture i_header_capture (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx_data    (rx_data),
    .rx_valid   (rx_valid),
    .capture_en (capture_en),
    .hdr_bytes  (hdr_bytes)
  );

  eth_header_parser i_eth_header_parser (
    .clk          (clk),
    .rst_n        (rst_n),
    .hdr_bytes    (hdr_bytes),
    .header_valid (header_valid),
    .hdr          (hdr),
    .fields_valid (fields_valid)
  );

  // Byte index at the last byte gives the length
  frame_classifier i_frame_classifier (
    .clk              (clk),
    .rst_n            (rst_n),
    .hdr              (hdr),
    .fields_valid     (fields_valid),
    .frame_end        (frame_end),
    .runt             (runt),
    .cfg              (cfg),
    .length           (byte_idx),
    .frame_info       (frame_info),
    .frame_info_valid (frame_info_valid),
    .events           (events)
  );

  // ------------------------------
  // Register block
  // ------------------------------
  l2_apb_regs i_l2_apb_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .events  (events),
    .cfg     (cfg)
  );

endmodule

// ==== test/tb_clk_gen.sv ====
// Testbench clock and reset generator
// 100 ns clock, reset low for the first two cycles

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  // Released on the second rising edge
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== test/tb_l2_parser.sv ====
// Testbench for the receive-side L2 header front end
// Directed frame and APB tests checked against a small reference model

`timescale 1ns/1ps
`include "l2_parser_defines.svh"

module tb_l2_parser;

  import l2_parser_pkg::*;

  localparam int        TIMEOUT   = 200;
  // Group bit is bit 0 of the first byte on the wire
  localparam mac_addr_t GROUP_BIT = 48'h0100_0000_0000;
  localparam mac_addr_t STATION   = 48'h001A_2B3C_4D5E;

  logic        clk;
  logic        rst_n;
  logic [7:0]  rx_data;
  logic        rx_valid;
  logic        rx_last;
  apb_addr_t   paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  apb_data_t   pwdata;
  apb_data_t   prdata;
  logic        pready;
  logic        pslverr;
  frame_info_t frame_info;
  logic        frame_info_valid;

  // Random source and reference model state
  logic [15:0] lfsr;
  mac_addr_t   station;
  logic        promisc;
  logic        mcast_en;
  int          n_accept;
  int          n_drop;
  int          n_runt;

  tb_clk_gen i_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  l2_parser_top i_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .rx_data          (rx_data),
    .rx_valid         (rx_valid),
    .rx_last          (rx_last),
    .paddr            (paddr),
    .psel             (psel),
    .penable          (penable),
    .pwrite           (pwrite),
    .pwdata           (pwdata),
    .prdata           (prdata),
    .pready           (pready),
    .pslverr          (pslverr),
    .frame_info       (frame_info),
    .frame_info_valid (frame_info_valid)
  );

  // ------------------------------
  // Random numbers and model
  // ------------------------------
  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic mac_addr_t rand_mac();
    return {16'(rand_bits(16)), rand_bits(32)};
  endfunction

  // Filter decision from the configured modes
  function automatic logic model_accept(input mac_addr_t dest);
    logic [7:0] first_byte;
    first_byte = dest[47:40];
    return (dest == station) || (dest == 48'hFFFF_FFFF_FFFF) ||
           (first_byte[0] && mcast_en) || promisc;
  endfunction

  // ------------------------------
  // Checking
  // ------------------------------
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                       input string what);
    if (actual !== expected) begin
      stop_on_error($sformatf("mismatch at %0t: %s, got 0x%0h, expected 0x%0h",
                              $time, what, actual, expected));
    end
  endtask

  // ------------------------------
  // APB
  // ------------------------------
  task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
    int waited;
    waited = 0;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (!pready) begin
      if (waited == TIMEOUT) begin
        stop_on_error($sformatf("pready never rose at %0t", $time));
      end
      waited++;
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    // Write lands on this edge
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    apb_data_t rdata;
    logic      err;
    apb_access(1'b1, addr, data, rdata, err);
    check(64'(err), 64'(0), "pslverr on write");
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
    logic err;
    apb_access(1'b0, addr, '0, data, err);
    check(64'(err), 64'(0), "pslverr on read");
  endtask

  task automatic read_expect(input apb_addr_t addr, input apb_data_t expected,
                             input string what);
    apb_data_t data;
    apb_read(addr, data);
    check(64'(data), 64'(expected), what);
  endtask

  task automatic set_filter_mode(input logic p, input logic m);
    apb_write(`L2_REG_CTRL, {30'b0, m, p});
    promisc  = p;
    mcast_en = m;
  endtask

  // ------------------------------
  // Stream
  // ------------------------------
  // Header plus random payload with an idle cycle before some bytes
  task automatic send_frame(input mac_addr_t dest, input logic has_tag, input logic [15:0] tci,
                            input ethertype_t etype, input int len);
    logic [7:0] frame_bytes[$];
    mac_addr_t  src;
    int         i;
    src = rand_mac();
    for (i = 0; i < 6; i++) begin
      frame_bytes.push_back(dest[47 - 8*i -: 8]);
    end
    for (i = 0; i < 6; i++) begin
      frame_bytes.push_back(src[47 - 8*i -: 8]);
    end
    if (has_tag) begin
      frame_bytes.push_back(8'h81);
      frame_bytes.push_back(8'h00);
      frame_bytes.push_back(tci[15:8]);
      frame_bytes.push_back(tci[7:0]);
    end
    frame_bytes.push_back(etype[15:8]);
    frame_bytes.push_back(etype[7:0]);
    while (frame_bytes.size() > len) begin
      void'(frame_bytes.pop_back());
    end
    while (frame_bytes.size() < len) begin
      frame_bytes.push_back(8'(rand_bits(8)));
    end
    for (i = 0; i < len; i++) begin
      @(posedge clk);
      if (rand_bits(2) == 0) begin
        rx_valid <= 1'b0;
        rx_last  <= 1'b0;
        @(posedge clk);
      end
      rx_valid <= 1'b1;
      rx_data  <= frame_bytes[i];
      rx_last  <= (i == len - 1);
    end
    // Last byte taken here
    @(posedge clk);
    rx_valid <= 1'b0;
    rx_last  <= 1'b0;
  endtask

  task automatic expect_info(input mac_addr_t dest, input logic has_tag, input logic [15:0] tci,
                             input ethertype_t etype, input int len);
    int   waited;
    logic acc;
    waited = 0;
    acc    = model_accept(dest);
    @(negedge clk);
    while (!frame_info_valid) begin
      if (waited == TIMEOUT) begin
        stop_on_error($sformatf("no frame_info_valid after a frame at %0t", $time));
      end
      waited++;
      @(negedge clk);
    end
    check(64'(frame_info.accept), 64'(acc), "accept");
    check(64'(frame_info.vlan_present), 64'(has_tag), "vlan_present");
    check(64'(frame_info.vlan_id), has_tag ? 64'(tci[11:0]) : 64'(0), "vlan_id");
    check(64'(frame_info.ethertype), 64'(etype), "ethertype");
    check(64'(frame_info.length), 64'(len), "length");
    if (acc) begin
      n_accept++;
    end else begin
      n_drop++;
    end
  endtask

  task automatic run_frame(input mac_addr_t dest, input logic has_tag, input logic [15:0] tci,
                           input ethertype_t etype, input int len);
    send_frame(dest, has_tag, tci, etype, len);
    expect_info(dest, has_tag, tci, etype, len);
  endtask

  // Short frame that must give no summary
  task automatic run_runt(input mac_addr_t dest, input int len);
    int waited;
    send_frame(dest, 1'b0, 16'h0, 16'h0800, len);
    for (waited = 0; waited < 40; waited++) begin
      @(negedge clk);
      if (frame_info_valid) begin
        stop_on_error($sformatf("frame_info_valid on a %0d byte runt at %0t", len, $time));
      end
    end
    n_runt++;
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic test_apb_regs();
    apb_data_t data;
    logic      err;
    apb_write(`L2_REG_MAC_LO, STATION[31:0]);
    // Upper half of MAC_HI is not stored
    apb_write(`L2_REG_MAC_HI, {16'hFFFF, STATION[47:32]});
    station = STATION;
    read_expect(`L2_REG_MAC_LO, STATION[31:0], "MAC_LO readback");
    read_expect(`L2_REG_MAC_HI, {16'h0, STATION[47:32]}, "MAC_HI readback");
    set_filter_mode(1'b1, 1'b1);
    read_expect(`L2_REG_CTRL, 32'h3, "CTRL readback");
    set_filter_mode(1'b0, 1'b0);
    read_expect(`L2_REG_CTRL, 32'h0, "CTRL cleared");
    apb_access(1'b0, 8'h40, '0, data, err);
    check(64'(err), 64'(1), "pslverr on unmapped offset");
  endtask

  task automatic test_untagged();
    run_frame(STATION, 1'b0, 16'h0, 16'h0800, 64);
    run_frame(STATION, 1'b0, 16'h0, 16'h86DD, 20);
  endtask

  task automatic test_vlan();
    run_frame(STATION, 1'b1, 16'hA123, 16'h0806, 60);
    run_frame(STATION, 1'b1, 16'h0FFF, 16'h0800, 22);
  endtask

  task automatic test_filter();
    set_filter_mode(1'b0, 1'b0);
    run_frame(48'h0011_2233_4455, 1'b0, 16'h0, 16'h0800, 40);
    run_frame(48'hFFFF_FFFF_FFFF, 1'b0, 16'h0, 16'h0806, 42);
    run_frame(48'h0100_5E00_0001, 1'b0, 16'h0, 16'h0800, 46);
    set_filter_mode(1'b0, 1'b1);
    run_frame(48'h0100_5E00_0001, 1'b1, 16'h2005, 16'h0800, 46);
    set_filter_mode(1'b1, 1'b0);
    run_frame(48'h0011_2233_4455, 1'b0, 16'h0, 16'h0800, 30);
    run_frame(48'h3333_0000_0001, 1'b0, 16'h0, 16'h86DD, 30);
    set_filter_mode(1'b0, 1'b0);
  endtask

  task automatic test_runt();
    run_runt(STATION, 1);
    run_runt(STATION, 12);
    run_runt(STATION, 19);
    read_expect(`L2_REG_RUNT_CNT, apb_data_t'(n_runt), "runt count");
    // Decode must recover on the next frame
    run_frame(STATION, 1'b1, 16'h6064, 16'h88CC, 20);
  endtask

  task automatic test_random_frames();
    int          n;
    mac_addr_t   dest;
    logic        has_tag;
    logic [15:0] tci;
    ethertype_t  etype;
    set_filter_mode(1'b0, 1'b1);
    for (n = 0; n < 30; n++) begin
      // Multicast drops in the second half
      if (n == 15) begin
        set_filter_mode(1'b0, 1'b0);
      end
      case (int'(rand_bits(2)))
        0:       dest = station;
        1:       dest = 48'hFFFF_FFFF_FFFF;
        2:       dest = rand_mac() | GROUP_BIT;
        default: dest = rand_mac() & ~GROUP_BIT;
      endcase
      has_tag = rand_bits(1) == 1;
      tci     = 16'(rand_bits(16));
      etype   = {8'h08, 8'(rand_bits(8))};
      if (rand_bits(3) == 0) begin
        run_runt(dest, 1 + int'(rand_bits(4)));
      end else begin
        run_frame(dest, has_tag, tci, etype, 20 + int'(rand_bits(5)));
      end
    end
    read_expect(`L2_REG_ACCEPT_CNT, apb_data_t'(n_accept), "accept count");
    read_expect(`L2_REG_DROP_CNT, apb_data_t'(n_drop), "drop count");
    read_expect(`L2_REG_RUNT_CNT, apb_data_t'(n_runt), "runt count");
    // Any write value clears
    apb_write(`L2_REG_ACCEPT_CNT, 32'hFFFF_FFFF);
    apb_write(`L2_REG_DROP_CNT, 32'h1234_5678);
    apb_write(`L2_REG_RUNT_CNT, 32'h0);
    read_expect(`L2_REG_ACCEPT_CNT, 32'h0, "accept count cleared");
    read_expect(`L2_REG_DROP_CNT, 32'h0, "drop count cleared");
    read_expect(`L2_REG_RUNT_CNT, 32'h0, "runt count cleared");
  endtask

  // ------------------------------
  // Sequence
  // ------------------------------
  initial begin
    int waited;
    rx_data  = '0;
    rx_valid = 1'b0;
    rx_last  = 1'b0;
    paddr    = '0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    pwdata   = '0;
    lfsr     = 16'd44259;
    station  = '0;
    promisc  = 1'b0;
    mcast_en = 1'b0;
    n_accept = 0;
    n_drop   = 0;
    n_runt   = 0;
    waited   = 0;
    while (rst_n !== 1'b1) begin
      if (waited == TIMEOUT) begin
        stop_on_error("reset was never released");
      end
      waited++;
      @(posedge clk);
    end
    test_apb_regs();
    test_untagged();
    test_vlan();
    test_filter();
    test_runt();
    test_random_frames();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+src
src/l2_parser_pkg.sv
src/byte_counter.sv
src/frame_ctrl_fsm.sv
src/header_capture.sv
src/eth_header_parser.sv
src/frame_classifier.sv
src/l2_apb_regs.sv
src/l2_parser_top.sv
test/tb_clk_gen.sv
test/tb_l2_parser.sv

// ==== Makefile ====
# Verilator build and run of the L2 header front end testbench

TOP := tb_l2_parser

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	  --top-module $(TOP) -f files.f -o V$(TOP)

# Pass only when the simulation prints the pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir
